// ==== common/simd_alu_defs.svh ====
// width and count macros for the simd alu
// shared by the package and every rtl unit
`ifndef SIMD_ALU_DEFS_SVH
`define SIMD_ALU_DEFS_SVH

// data word width
`define ALU_WIDTH 32

// number of byte lanes in one word
`define LANE_COUNT 4

// width of one byte lane
`define BYTE_WIDTH 8

// bit count result, wide enough to hold 32
`define BITCNT_WIDTH 6

// divider iterations, one quotient bit each
`define DIV_ITER 32

// operator encoding width
`define OP_WIDTH 6

`endif

// ==== common/simd_alu_pkg.sv ====
// word, lane-flag and bit-count types, operator and vector-mode
// encodings, divider states
`include "simd_alu_defs.svh"

package simd_alu_pkg;

  typedef logic [`ALU_WIDTH-1:0]    word_t;
  typedef logic [`LANE_COUNT-1:0]   lane_flags_t;
  typedef logic [`BITCNT_WIDTH-1:0] bitcnt_t;

  // two 16 bit lanes or four 8 bit lanes share the datapath
  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  typedef enum logic [`OP_WIDTH-1:0] {
    // arithmetic and shifts
    ALU_ADD  = 6'h00, ALU_SUB  = 6'h01, ALU_ABS  = 6'h02,
    ALU_SLL  = 6'h04, ALU_SRL  = 6'h05, ALU_SRA  = 6'h06, ALU_ROR  = 6'h07,
    // bitwise logic
    ALU_AND  = 6'h08, ALU_OR   = 6'h09, ALU_XOR  = 6'h0a,
    // lane comparisons
    ALU_EQ   = 6'h10, ALU_NE   = 6'h11, ALU_GTS  = 6'h12, ALU_GTU  = 6'h13,
    ALU_GES  = 6'h14, ALU_GEU  = 6'h15, ALU_LTS  = 6'h16, ALU_LTU  = 6'h17,
    ALU_LES  = 6'h18, ALU_LEU  = 6'h19, ALU_SLTS = 6'h1a, ALU_SLTU = 6'h1b,
    ALU_MIN  = 6'h1c, ALU_MINU = 6'h1d, ALU_MAX  = 6'h1e, ALU_MAXU = 6'h1f,
    // bit counting
    ALU_FF1  = 6'h20, ALU_FL1  = 6'h21, ALU_CNT  = 6'h22, ALU_CLB  = 6'h23,
    // divide group, bit 0 signed and bit 1 remainder
    ALU_DIVU = 6'h30, ALU_DIV  = 6'h31, ALU_REMU = 6'h32, ALU_REM  = 6'h33
  } alu_op_e;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'b00,
    DIV_BUSY = 2'b01,
    DIV_DONE = 2'b10
  } div_state_e;

endpackage

// ==== src/partitioned_adder.sv ====
`timescale 1ns/10ps
// carry-separated adder for add, sub and abs negation in 32, 16 or 8 bit lanes
`include "simd_alu_defs.svh"

module partitioned_adder (
  input  simd_alu_pkg::alu_op_e   operator_i,
  input  simd_alu_pkg::vec_mode_e vector_mode_i,
  input  simd_alu_pkg::word_t     operand_a_i,
  input  simd_alu_pkg::word_t     operand_b_i,
  output simd_alu_pkg::word_t     sum_o
);
  import simd_alu_pkg::*;

  // one separator bit below every byte
  localparam int SLOT_W = `BYTE_WIDTH + 1;
  localparam int EXT_W  = `ALU_WIDTH + `LANE_COUNT;

  logic             negate;
  word_t            op_a;
  word_t            op_b;
  lane_flags_t      lane_start;
  logic [EXT_W-1:0] in_a;
  logic [EXT_W-1:0] in_b;
  logic [EXT_W-1:0] sum_ext;

  assign negate = (operator_i == ALU_SUB) || (operator_i == ALU_ABS);

  // abs is zero minus a
  assign op_a = (operator_i == ALU_ABS) ? ~operand_a_i : operand_a_i;
  assign op_b = (operator_i == ALU_SUB) ? ~operand_b_i :
                (operator_i == ALU_ABS) ? '0 : operand_b_i;

  // bytes that open a new lane
  assign lane_start = (vector_mode_i == VEC_MODE8)  ? 4'b1110 :
                      (vector_mode_i == VEC_MODE16) ? 4'b0100 : 4'b0000;

  always_comb begin
    for (int i = 0; i < `LANE_COUNT; i++) begin
      // default separator lets the carry ripple through
      in_a[SLOT_W*i]                    = 1'b1;
      in_b[SLOT_W*i]                    = 1'b0;
      in_a[SLOT_W*i+1 +: `BYTE_WIDTH] = op_a[`BYTE_WIDTH*i +: `BYTE_WIDTH];
      in_b[SLOT_W*i+1 +: `BYTE_WIDTH] = op_b[`BYTE_WIDTH*i +: `BYTE_WIDTH];
      if (lane_start[i]) begin
        // 1+1 injects the +1 of negation, 0+0 kills the carry
        if (negate) begin
          in_b[SLOT_W*i] = 1'b1;
        end else begin
          in_a[SLOT_W*i] = 1'b0;
        end
      end
    end
    // carry into the lowest lane
    in_b[0] = negate;
  end

  assign sum_ext = in_a + in_b;

  // drop the separators again
  for (genvar i = 0; i < `LANE_COUNT; i++) begin : gen_sum
    assign sum_o[`BYTE_WIDTH*i +: `BYTE_WIDTH] = sum_ext[SLOT_W*i+1 +: `BYTE_WIDTH];
  end

endmodule

// ==== src/lane_shifter.sv ====
`timescale 1ns/10ps
// per-lane right shifter, left shifts by bit reversal, 32 bit rotate right
`include "simd_alu_defs.svh"

module lane_shifter (
  input  simd_alu_pkg::alu_op_e   operator_i,
  input  simd_alu_pkg::vec_mode_e vector_mode_i,
  input  simd_alu_pkg::word_t     operand_a_i,
  input  simd_alu_pkg::word_t     operand_b_i,
  output simd_alu_pkg::word_t     shift_o
);
  import simd_alu_pkg::*;

  localparam int HALF_W = `ALU_WIDTH / 2;

  logic                    shift_left;
  logic                    shift_arith;
  word_t                   op_rev;
  word_t                   amt_left;
  word_t                   amt;
  word_t                   shift_in;
  word_t                   right_res;
  logic [2*`ALU_WIDTH-1:0] wide_in;
  logic [2*`ALU_WIDTH-1:0] wide_sh;
  logic [HALF_W:0]         half_sh [2];
  logic [`BYTE_WIDTH:0]    byte_sh [`LANE_COUNT];

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);

  // input and output bit reversal turn the right shifter into a left one
  for (genvar i = 0; i < `ALU_WIDTH; i++) begin : gen_rev
    assign op_rev[i]  = operand_a_i[`ALU_WIDTH-1-i];
    assign shift_o[i] = shift_left ? right_res[`ALU_WIDTH-1-i] : right_res[i];
  end

  // reversed data also needs the lane amounts in reverse order
  always_comb begin
    case (vector_mode_i)
      VEC_MODE16: amt_left = {operand_b_i[HALF_W-1:0], operand_b_i[`ALU_WIDTH-1:HALF_W]};
      VEC_MODE8: begin
        for (int i = 0; i < `LANE_COUNT; i++) begin
          amt_left[`BYTE_WIDTH*i +: `BYTE_WIDTH] =
            operand_b_i[`BYTE_WIDTH*(`LANE_COUNT-1-i) +: `BYTE_WIDTH];
        end
      end
      default: amt_left = operand_b_i;
    endcase
  end

  assign amt      = shift_left ? amt_left : operand_b_i;
  assign shift_in = shift_left ? op_rev : operand_a_i;

  // rotate shifts a doubled word, otherwise the upper half is sign or zero fill
  assign wide_in = (operator_i == ALU_ROR) ? {shift_in, shift_in} :
                   {{`ALU_WIDTH{shift_arith & shift_in[`ALU_WIDTH-1]}}, shift_in};
  assign wide_sh = wide_in >> amt[4:0];

  // 16 bit lanes, 4 bit amounts
  for (genvar h = 0; h < 2; h++) begin : gen_half
    assign half_sh[h] = $signed({shift_arith & shift_in[HALF_W*h+HALF_W-1],
                                 shift_in[HALF_W*h +: HALF_W]}) >>> amt[HALF_W*h +: 4];
  end

  // 8 bit lanes, 3 bit amounts
  for (genvar b = 0; b < `LANE_COUNT; b++) begin : gen_byte
    assign byte_sh[b] = $signed({shift_arith & shift_in[`BYTE_WIDTH*b+`BYTE_WIDTH-1],
                                 shift_in[`BYTE_WIDTH*b +: `BYTE_WIDTH]})
                        >>> amt[`BYTE_WIDTH*b +: 3];
  end

  always_comb begin
    case (vector_mode_i)
      VEC_MODE16: right_res = {half_sh[1][HALF_W-1:0], half_sh[0][HALF_W-1:0]};
      VEC_MODE8: begin
        for (int i = 0; i < `LANE_COUNT; i++) begin
          right_res[`BYTE_WIDTH*i +: `BYTE_WIDTH] = byte_sh[i][`BYTE_WIDTH-1:0];
        end
      end
      default: right_res = wide_sh[`ALU_WIDTH-1:0];
    endcase
  end

  // rotate has no lane form
  always_comb begin
    assert final ($isunknown(operator_i) || operator_i != ALU_ROR ||
                  vector_mode_i == VEC_MODE32);
  end

endmodule

// ==== src/lane_comparator.sv ====
`timescale 1ns/10ps
// per-byte equal and greater flags merged by vector mode, compare result, min/max/abs select
`include "simd_alu_defs.svh"

module lane_comparator (
  input  simd_alu_pkg::alu_op_e     operator_i,
  input  simd_alu_pkg::vec_mode_e   vector_mode_i,
  input  simd_alu_pkg::word_t       operand_a_i,
  input  simd_alu_pkg::word_t       operand_b_i,
  input  simd_alu_pkg::word_t       sum_i,
  output simd_alu_pkg::lane_flags_t cmp_flags_o,
  output logic                      comparison_result_o,
  output simd_alu_pkg::word_t       minmax_o
);
  import simd_alu_pkg::*;

  word_t       cmp_b;
  logic        signed_op;
  logic        do_min;
  lane_flags_t cmp_signed;
  lane_flags_t eq_byte;
  lane_flags_t gt_byte;
  lane_flags_t is_eq;
  lane_flags_t is_gt;
  lane_flags_t sel_a;

  // abs compares a against its own negation
  assign cmp_b = (operator_i == ALU_ABS) ? sum_i : operand_b_i;

  assign signed_op = operator_i inside {ALU_GTS, ALU_GES, ALU_LTS, ALU_LES, ALU_SLTS,
                                        ALU_MIN, ALU_MAX, ALU_ABS};

  // sign bit only at the top byte of each lane
  assign cmp_signed = !signed_op                   ? 4'b0000 :
                      (vector_mode_i == VEC_MODE8)  ? 4'b1111 :
                      (vector_mode_i == VEC_MODE16) ? 4'b1010 : 4'b1000;

  for (genvar i = 0; i < `LANE_COUNT; i++) begin : gen_byte_cmp
    assign eq_byte[i] = operand_a_i[`BYTE_WIDTH*i +: `BYTE_WIDTH] ==
                        cmp_b[`BYTE_WIDTH*i +: `BYTE_WIDTH];
    assign gt_byte[i] =
      $signed({operand_a_i[`BYTE_WIDTH*i+`BYTE_WIDTH-1] & cmp_signed[i],
               operand_a_i[`BYTE_WIDTH*i +: `BYTE_WIDTH]}) >
      $signed({cmp_b[`BYTE_WIDTH*i+`BYTE_WIDTH-1] & cmp_signed[i],
               cmp_b[`BYTE_WIDTH*i +: `BYTE_WIDTH]});
  end

  // merge bytes into lanes, upper byte decides unless equal
  always_comb begin
    case (vector_mode_i)
      VEC_MODE8: begin
        is_eq = eq_byte;
        is_gt = gt_byte;
      end
      VEC_MODE16: begin
        is_eq[1:0] = {2{&eq_byte[1:0]}};
        is_eq[3:2] = {2{&eq_byte[3:2]}};
        is_gt[1:0] = {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}};
        is_gt[3:2] = {2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}};
      end
      default: begin
        is_eq = {4{&eq_byte}};
        is_gt = {4{gt_byte[3] | (eq_byte[3] & (gt_byte[2] | (eq_byte[2] &
                   (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
      end
    endcase
  end

  always_comb begin
    case (operator_i)
      ALU_NE:                               cmp_flags_o = ~is_eq;
      ALU_GTS, ALU_GTU:                     cmp_flags_o = is_gt;
      ALU_GES, ALU_GEU:                     cmp_flags_o = is_gt | is_eq;
      ALU_LTS, ALU_LTU, ALU_SLTS, ALU_SLTU: cmp_flags_o = ~(is_gt | is_eq);
      ALU_LES, ALU_LEU:                     cmp_flags_o = ~is_gt;
      default:                              cmp_flags_o = is_eq;
    endcase
  end

  // scalar result comes from the top lane
  assign comparison_result_o = cmp_flags_o[`LANE_COUNT-1];

  // max and abs keep a when greater, min inverts the choice
  assign do_min = (operator_i == ALU_MIN) || (operator_i == ALU_MINU);
  assign sel_a  = is_gt ^ {`LANE_COUNT{do_min}};

  for (genvar i = 0; i < `LANE_COUNT; i++) begin : gen_minmax
    assign minmax_o[`BYTE_WIDTH*i +: `BYTE_WIDTH] = sel_a[i] ?
      operand_a_i[`BYTE_WIDTH*i +: `BYTE_WIDTH] : cmp_b[`BYTE_WIDTH*i +: `BYTE_WIDTH];
  end

endmodule

// ==== src/bit_counter.sv ====
`timescale 1ns/10ps
// population count, first and last one index, leading sign bit count
`include "simd_alu_defs.svh"

module bit_counter (
  input  simd_alu_pkg::alu_op_e operator_i,
  input  simd_alu_pkg::word_t   operand_a_i,
  output simd_alu_pkg::bitcnt_t count_o
);
  import simd_alu_pkg::*;

  bitcnt_t pop_cnt;
  bitcnt_t ff1_idx;
  bitcnt_t fl1_idx;
  bitcnt_t sign_hi;
  bitcnt_t clb_cnt;
  word_t   clb_src;
  logic    clb_none;

  // invert negative words so leading sign bits become leading zeros
  assign clb_src = operand_a_i[`ALU_WIDTH-1] ? ~operand_a_i : operand_a_i;

  always_comb begin
    pop_cnt  = '0;
    ff1_idx  = bitcnt_t'(`ALU_WIDTH);
    fl1_idx  = bitcnt_t'(`ALU_WIDTH);
    sign_hi  = '0;
    clb_none = 1'b1;
    // upward scan, last hit is the highest bit
    for (int i = 0; i < `ALU_WIDTH; i++) begin
      pop_cnt = pop_cnt + bitcnt_t'(operand_a_i[i]);
      if (operand_a_i[i]) begin
        fl1_idx = bitcnt_t'(i);
      end
      if (clb_src[i]) begin
        sign_hi  = bitcnt_t'(i);
        clb_none = 1'b0;
      end
    end
    // downward scan, last hit is the lowest bit
    for (int i = `ALU_WIDTH - 1; i >= 0; i--) begin
      if (operand_a_i[i]) begin
        ff1_idx = bitcnt_t'(i);
      end
    end
  end

  // all zeros gives 0, all ones gives 31
  assign clb_cnt = clb_none ? (operand_a_i[`ALU_WIDTH-1] ? bitcnt_t'(`ALU_WIDTH - 1) : '0) :
                   bitcnt_t'(`ALU_WIDTH - 2) - sign_hi;

  always_comb begin
    case (operator_i)
      ALU_CNT: count_o = pop_cnt;
      ALU_FF1: count_o = ff1_idx;
      ALU_FL1: count_o = fl1_idx;
      ALU_CLB: count_o = clb_cnt;
      default: count_o = '0;
    endcase
  end

endmodule

// ==== div/serial_divider.sv ====
`timescale 1ns/10ps
// restoring serial divider for div, divu, rem and remu
// with idle/busy/done control and result hold under back-pressure
`include "simd_alu_defs.svh"

module serial_divider (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  simd_alu_pkg::alu_op_e operator_i,
  input  simd_alu_pkg::word_t   dividend_i,
  input  simd_alu_pkg::word_t   divisor_i,
  input  logic                  ex_ready_i,
  output simd_alu_pkg::word_t   result_o,
  output logic                  ready_o
);
  import simd_alu_pkg::*;

  localparam int CNT_W = $clog2(`DIV_ITER) + 1;

  div_state_e            state_q;
  logic [CNT_W-1:0]      iter_q;
  logic                  signed_op;
  logic                  sign_a;
  logic                  sign_b;
  logic                  load;
  word_t                 mag_a;
  word_t                 mag_b;
  logic [`ALU_WIDTH+1:0] trial;
  // datapath
  word_t                 rem_q;
  word_t                 quot_q;
  word_t                 dvs_q;
  logic                  rem_op_q;
  logic                  neg_quot_q;
  logic                  neg_rem_q;
  word_t                 quot_fix;
  word_t                 rem_fix;

  //////////////////////////////
  // operand preparation
  //////////////////////////////

  // opcode bit 0 selects signed, bit 1 remainder
  assign signed_op = operator_i[0];
  assign sign_a    = signed_op & dividend_i[`ALU_WIDTH-1];
  assign sign_b    = signed_op & divisor_i[`ALU_WIDTH-1];
  assign mag_a     = sign_a ? -dividend_i : dividend_i;
  assign mag_b     = sign_b ? -divisor_i : divisor_i;
  assign load      = (state_q == DIV_IDLE) && start_i;

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= DIV_IDLE;
      iter_q  <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (start_i) begin
            state_q <= DIV_BUSY;
            iter_q  <= '0;
          end
        end
        DIV_BUSY: begin
          iter_q <= iter_q + 1'b1;
          // last quotient bit goes in on this edge
          if (iter_q == CNT_W'(`DIV_ITER - 1)) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          // hold the result until the next stage takes it
          if (ex_ready_i) begin
            state_q <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // restoring iteration
  //////////////////////////////

  // next dividend bit shifted into the partial remainder, msb is the borrow
  assign trial = {1'b0, rem_q, quot_q[`ALU_WIDTH-1]} - {2'b00, dvs_q};

  always_ff @(posedge clk) begin
    if (load) begin
      rem_q      <= '0;
      quot_q     <= mag_a;
      dvs_q      <= mag_b;
      rem_op_q   <= operator_i[1];
      // divide by zero keeps the all ones quotient unsigned
      neg_quot_q <= (sign_a ^ sign_b) && (divisor_i != '0);
      neg_rem_q  <= sign_a;
    end else if (state_q == DIV_BUSY) begin
      quot_q <= {quot_q[`ALU_WIDTH-2:0], ~trial[`ALU_WIDTH+1]};
      if (!trial[`ALU_WIDTH+1]) begin
        rem_q <= trial[`ALU_WIDTH-1:0];
      end else begin
        rem_q <= {rem_q[`ALU_WIDTH-2:0], quot_q[`ALU_WIDTH-1]};
      end
    end
  end

  // sign fix, remainder follows the dividend
  assign quot_fix = neg_quot_q ? -quot_q : quot_q;
  assign rem_fix  = neg_rem_q ? -rem_q : rem_q;

  assign result_o = (state_q == DIV_DONE) ? (rem_op_q ? rem_fix : quot_fix) : '0;
  assign ready_o  = (state_q != DIV_BUSY);

  assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q == DIV_BUSY) |-> (iter_q < CNT_W'(`DIV_ITER)));

endmodule

// ==== src/simd_alu.sv ====
`timescale 1ns/10ps
// simd alu top level with unit instances and the result multiplexer
`include "simd_alu_defs.svh"

module simd_alu (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    enable_i,
  input  simd_alu_pkg::alu_op_e   operator_i,
  input  simd_alu_pkg::vec_mode_e vector_mode_i,
  input  simd_alu_pkg::word_t     operand_a_i,
  input  simd_alu_pkg::word_t     operand_b_i,
  input  logic                    ex_ready_i,
  output simd_alu_pkg::word_t     result_o,
  output logic                    comparison_result_o,
  output logic                    ready_o
);
  import simd_alu_pkg::*;

  word_t       sum;
  word_t       shift_res;
  word_t       minmax;
  word_t       div_result;
  word_t       lane_mask;
  lane_flags_t cmp_flags;
  bitcnt_t     bit_count;
  logic        div_start;
  logic        div_ready;

  //////////////////////////////
  // execution units
  //////////////////////////////

  partitioned_adder adder0 (
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .sum_o         (sum)
  );

  lane_shifter shifter0 (
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .shift_o       (shift_res)
  );

  // sum doubles as the negated operand for abs
  lane_comparator comparator0 (
    .operator_i          (operator_i),
    .vector_mode_i       (vector_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .sum_i               (sum),
    .cmp_flags_o         (cmp_flags),
    .comparison_result_o (comparison_result_o),
    .minmax_o            (minmax)
  );

  bit_counter counter0 (
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .count_o     (bit_count)
  );

  // only the divide group starts the serial divider
  assign div_start = enable_i && (operator_i inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU});

  serial_divider divider0 (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (div_start),
    .operator_i (operator_i),
    .dividend_i (operand_a_i),
    .divisor_i  (operand_b_i),
    .ex_ready_i (ex_ready_i),
    .result_o   (div_result),
    .ready_o    (div_ready)
  );

  assign ready_o = div_ready;

  //////////////////////////////
  // result multiplexer
  //////////////////////////////

  // each lane flag spread over its byte
  for (genvar i = 0; i < `LANE_COUNT; i++) begin : gen_lane_mask
    assign lane_mask[`BYTE_WIDTH*i +: `BYTE_WIDTH] = {`BYTE_WIDTH{cmp_flags[i]}};
  end

  always_comb begin
    result_o = '0;
    unique case (operator_i)
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_ADD, ALU_SUB: result_o = sum;
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR: result_o = shift_res;
      // abs picks between a and its negation in the comparator
      ALU_ABS, ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU: result_o = minmax;
      ALU_EQ, ALU_NE, ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU,
      ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU: result_o = lane_mask;
      // scalar set-less-than lands in bit 0
      ALU_SLTS, ALU_SLTU: result_o = {{(`ALU_WIDTH-1){1'b0}}, comparison_result_o};
      ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB:
        result_o = {{(`ALU_WIDTH-`BITCNT_WIDTH){1'b0}}, bit_count};
      ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU: result_o = div_result;
      default: ;
    endcase
  end

  // a ready result never carries unknown bits, divide results included
  assert property (@(posedge clk) disable iff (!rst_n_i) ready_o |-> !$isunknown(result_o));

endmodule

// ==== verif/simd_alu_tb.sv ====
`timescale 1ns/10ps
// simd alu testbench with clock, reset, trace replay and divide handshake checks
// cycle watchdog and closing error summary

module simd_alu_tb;
  import simd_alu_pkg::*;

  localparam int CLK_HALF     = 4;
  localparam int RESET_CYCLES = 5;
  localparam int MAX_RECORDS  = 64;
  // op, mode, a, b, stall, result, flag
  localparam int FIELDS       = 7;
  // comment lines ahead of the first record
  localparam int HEADER_LINES = 2;
  // sampling edge included
  localparam int DIV_EDGES    = 33;
  localparam logic [31:0] FLAG_SKIP = 32'h0000_000f;

  logic      clk;
  logic      rst_n_i;
  logic      enable_i;
  alu_op_e   operator_i;
  vec_mode_e vector_mode_i;
  word_t     operand_a_i;
  word_t     operand_b_i;
  logic      ex_ready_i;
  word_t     result_o;
  logic      comparison_result_o;
  logic      ready_o;

  logic [31:0] trace_mem [MAX_RECORDS*FIELDS];
  int          record_cnt;
  int          max_stall;
  int          cycle_limit;
  int          cycle_cnt = 0;
  int          error_cnt;
  int          check_cnt;

  simd_alu dut0 (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .enable_i            (enable_i),
    .operator_i          (operator_i),
    .vector_mode_i       (vector_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .ex_ready_i          (ex_ready_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .ready_o             (ready_o)
  );

  //////////////////////////////
  // clock and watchdog
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt > cycle_limit);
    $display("timeout after %0d cycles, %0d errors so far", cycle_cnt, error_cnt);
    $display("Test FAILED");
    $finish;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // marks unused memory words, so the end of the trace shows up
  function automatic logic [31:0] fill_word(int addr);
    return 32'hfeed_0000 ^ 32'(addr);
  endfunction

  function automatic logic is_divide(alu_op_e op);
    return op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  endfunction

  // test name is the trace line number
  function automatic string line_name(int idx);
    return $sformatf("line %0d", idx + HEADER_LINES + 1);
  endfunction

  task automatic load_trace();
    int stall;
    for (int i = 0; i < MAX_RECORDS*FIELDS; i++) begin
      trace_mem[i] = fill_word(i);
    end
    $readmemh("verif/simd_alu_trace.txt", trace_mem);
    record_cnt = 0;
    max_stall  = 0;
    while (record_cnt < MAX_RECORDS &&
           trace_mem[record_cnt*FIELDS] != fill_word(record_cnt*FIELDS)) begin
      stall = int'(trace_mem[record_cnt*FIELDS+4]);
      if (stall > max_stall) begin
        max_stall = stall;
      end
      record_cnt++;
    end
    // worst case per record is a divide plus its stall and the return to idle
    cycle_limit = record_cnt * (DIV_EDGES + max_stall + 4) + RESET_CYCLES;
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("Mismatch %s flag: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
  endtask

  // called on a falling edge
  task automatic drive_record(int idx);
    int base;
    base          = idx * FIELDS;
    enable_i      = 1'b1;
    operator_i    = alu_op_e'(trace_mem[base][5:0]);
    vector_mode_i = vec_mode_e'(trace_mem[base+1][1:0]);
    operand_a_i   = trace_mem[base+2];
    operand_b_i   = trace_mem[base+3];
    // a stalled divide keeps the next stage busy until the stall ends
    ex_ready_i    = !is_divide(operator_i) || (trace_mem[base+4] == 32'h0);
  endtask

  task automatic run_record(int idx);
    string name;
    int    base;
    int    stall;
    int    edges;
    word_t held;
    base  = idx * FIELDS;
    name  = line_name(idx);
    stall = int'(trace_mem[base+4]);
    drive_record(idx);
    @(negedge clk);
    if (!is_divide(operator_i)) begin
      check_word(name, trace_mem[base+5], result_o);
      if (trace_mem[base+6] != FLAG_SKIP) begin
        check_bit(name, trace_mem[base+6][0], comparison_result_o);
      end
      if (!ready_o) begin
        error_cnt++;
        $display("%s: ready_o low on a single-cycle operation", name);
      end
    end else begin
      // the sampling edge is already behind us
      edges = 1;
      if (ready_o) begin
        error_cnt++;
        $display("%s: ready_o still high one cycle after the divide started", name);
      end
      while (!ready_o) begin
        @(negedge clk);
        edges++;
      end
      check_cnt++;
      if (edges != DIV_EDGES) begin
        error_cnt++;
        $display("Mismatch %s latency: expected %0d, actual %0d", name, DIV_EDGES, edges);
      end
      check_word(name, trace_mem[base+5], result_o);
      held = result_o;
      // result held while the next stage stalls
      repeat (stall) begin
        @(negedge clk);
        check_cnt++;
        if (!ready_o || result_o !== held) begin
          error_cnt++;
          $display("%s: result or ready_o changed while ex_ready_i was low", name);
        end
      end
      ex_ready_i = 1'b1;
      // one edge to hand the result over and go back to idle
      @(negedge clk);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    error_cnt     = 0;
    check_cnt     = 0;
    rst_n_i       = 1'b0;
    enable_i      = 1'b0;
    operator_i    = ALU_ADD;
    vector_mode_i = VEC_MODE32;
    operand_a_i   = '0;
    operand_b_i   = '0;
    ex_ready_i    = 1'b1;
    load_trace();
    if (record_cnt == 0) begin
      error_cnt++;
      $display("trace file holds no records");
    end else begin
      apply_reset();
      for (int i = 0; i < record_cnt; i++) begin
        run_record(i);
      end
    end
    $display("%0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/simd_alu_trace.txt ====
// op mode a b stall result flag, one operation per line in hex
// mode 0 2 3 selects 32 16 8 bit lanes and flag f is not checked
00 3 00ff7f80 00010180 0 00008000 f
00 2 ffff0001 00010002 0 00000003 f
00 0 ffffffff 00000002 0 00000001 f
01 3 00102030 01010101 0 ff0f1f2f f
01 0 00000000 00000001 0 ffffffff f
02 3 80ff0105 00000000 0 80010105 f
02 2 fffe0003 00000000 0 00020003 f
02 0 fffffff6 00000000 0 0000000a f
04 3 01010101 00010203 0 01020408 f
04 2 00010001 00040008 0 00100100 f
04 0 00000001 0000001f 0 80000000 f
05 3 80808080 00010207 0 80402001 f
05 0 f0000000 00000024 0 0f000000 f
06 3 80808080 00010207 0 80c0e0ff f
06 2 80007fff 000f0004 0 ffff07ff f
07 0 12345678 00000008 0 78123456 f
0a 0 0f0f0f0f ffff0000 0 f0f00f0f f
10 3 11223344 11003300 0 ff00ff00 1
11 2 12340000 12350000 0 ffff0000 1
12 3 80017f00 01008000 0 00ffff00 0
13 3 80017f00 01008000 0 ffff0000 1
14 2 ffff0005 00000005 0 0000ffff 0
16 0 80000000 00000001 0 ffffffff 1
18 3 05ff0280 05000180 0 ffff00ff 1
1a 0 ffffffff 00000000 0 00000001 1
1b 0 ffffffff 00000000 0 00000000 0
1c 3 7f80ff01 80010000 0 8080ff00 f
1d 3 7f80ff01 80010000 0 7f010000 f
1e 2 8000ffff 00010001 0 00010001 f
1f 2 8000ffff 00010001 0 8000ffff f
20 0 00010000 00000000 0 00000010 f
20 0 00000000 00000000 0 00000020 f
21 0 80000000 00000000 0 0000001f f
22 0 f0f00001 00000000 0 00000009 f
23 0 00000000 00000000 0 00000000 f
23 0 ffffffff 00000000 0 0000001f f
23 0 0000ffff 00000000 0 0000000f f
30 0 00000064 00000007 0 0000000e f
31 0 ffffff9c 00000007 3 fffffff2 f
33 0 ffffff9c 00000007 0 fffffffe f
32 0 ffffff9c 00000007 0 00000002 f
33 0 00000064 fffffff9 2 00000002 f
30 0 12345678 00000000 0 ffffffff f
31 0 fffffff0 00000000 0 ffffffff f
33 0 87654321 00000000 0 87654321 f
31 0 80000000 ffffffff 1 80000000 f
33 0 80000000 ffffffff 0 00000000 f

// ==== simd_alu.f ====
+incdir+common
common/simd_alu_pkg.sv
src/partitioned_adder.sv
src/lane_shifter.sv
src/lane_comparator.sv
src/bit_counter.sv
div/serial_divider.sv
src/simd_alu.sv
verif/simd_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the simd alu testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert \
  --top-module simd_alu_tb -Mdir obj_dir -o simd_alu_sim \
  -f simd_alu.f > build.log 2>&1 \
  && ./obj_dir/simd_alu_sim > sim.log 2>&1 \
  || echo "build or run error, see build.log and sim.log"
grep -qx "Test OK" sim.log \
  && echo "simulation passed" \
  && exit 0 \
  || { echo "simulation failed"; exit 1; }
